// ==== logic/rbus_pkg.sv ====
// rbus shared definitions
// word and frame types, class flags, counters and the scheduler encodings
// for the two-input, two-class packet multiplexer
package rbus_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------
    localparam int WORD_W             = 72;
    localparam int LONG_WORDS         = 8;  // header included
    localparam int SHORT_SLOTS        = 4;  // one word each
    localparam int LONG_SLOTS         = 2;  // LONG_WORDS each
    localparam int DOWN_SHORT_CREDITS = 4;  // receiver short buffer depth
    localparam int DOWN_LONG_CREDITS  = 2;  // receiver long buffer depth
    localparam int HDR_LONG_BIT       = 71; // set in header -> long packet

    // ----------------------------------------
    // bus types
    // ----------------------------------------
    typedef logic [WORD_W-1:0] rbus_word_t;

    // one word on the frame bus
    typedef struct packed {
        logic       stb;  // word valid
        logic       sof;  // first word of packet
        rbus_word_t data;
    } rbus_frm_t;

    // one flag per packet class
    // credit pulses, availability, pop requests
    typedef struct packed {
        logic short_p;
        logic long_p;
    } rbus_class_t;

    typedef logic [2:0] rbus_wcnt_t; // word index in a long packet
    typedef logic [2:0] rbus_cred_t; // credit and slot counts, max 4

    // ----------------------------------------
    // scheduler
    // ----------------------------------------
    // candidates, also the last-grant pointer
    typedef enum logic [1:0] {
        A_SHORT = 2'd0,
        A_LONG  = 2'd1,
        B_SHORT = 2'd2,
        B_LONG  = 2'd3
    } rbus_src_t;

    typedef enum logic {
        S_IDLE = 1'b0, // nothing in flight
        S_SEND = 1'b1  // queue streaming the granted packet
    } sched_state_t;

endpackage

// ==== logic/rbus_class_queue.sv ====
// rbus class queue
// stores one input's packets in separate short and long buffers,
// streams a whole packet on pop and returns one upstream credit
// per packet read out; flags framing and overflow violations
module rbus_class_queue (
    input  logic                  clk,
    input  logic                  rst,
    input  rbus_pkg::rbus_frm_t   i_frm,
    output rbus_pkg::rbus_class_t o_cred,
    output rbus_pkg::rbus_class_t o_avail,
    input  rbus_pkg::rbus_class_t i_pop,
    output rbus_pkg::rbus_frm_t   o_word,
    output logic                  o_err
);
    import rbus_pkg::*;

    typedef logic [$clog2(SHORT_SLOTS)-1:0] sptr_t;
    typedef logic [$clog2(LONG_SLOTS)-1:0]  lptr_t;

    // ----------------------------------------
    // storage and state
    // ----------------------------------------
    rbus_word_t  s_mem [SHORT_SLOTS];
    rbus_word_t  l_mem [LONG_SLOTS][LONG_WORDS];

    sptr_t       s_wr;
    sptr_t       s_rd;
    lptr_t       l_wr;
    lptr_t       l_rd;
    rbus_cred_t  s_cnt;   // complete short packets not yet popped
    rbus_cred_t  l_cnt;   // complete long packets not yet popped
    rbus_cred_t  s_used;  // slots held until credit goes back
    rbus_cred_t  l_used;

    logic        w_busy;  // long packet being written
    logic        w_drop;  // ... into a full buffer, body discarded
    rbus_wcnt_t  w_idx;   // next body word index

    logic        r_long;  // long readout in progress
    rbus_wcnt_t  r_idx;   // next word to read
    rbus_class_t w_last;  // o_word holds a packet's last word

    // write side decode
    logic        hdr;
    logic        body;
    logic        hdr_long;
    logic        s_full;
    logic        l_full;
    logic        w_end;
    logic        s_wr_en;
    logic        l_wr_en;
    logic        l_wr_done;
    rbus_wcnt_t  l_wr_idx;
    logic        r_end;
    logic        err_now;

    assign hdr       = i_frm.stb & i_frm.sof;
    assign body      = i_frm.stb & ~i_frm.sof;
    assign hdr_long  = i_frm.data[HDR_LONG_BIT];
    assign s_full    = (s_used == rbus_cred_t'(SHORT_SLOTS));
    assign l_full    = (l_used == rbus_cred_t'(LONG_SLOTS));
    assign w_end     = body & w_busy & (w_idx == rbus_wcnt_t'(LONG_WORDS - 1));
    assign s_wr_en   = hdr & ~hdr_long & ~s_full;
    assign l_wr_en   = (hdr & hdr_long & ~l_full) | (body & w_busy & ~w_drop);
    assign l_wr_done = w_end & ~w_drop;                  // packet now complete
    assign l_wr_idx  = hdr ? '0 : w_idx;                 // header always word 0
    assign r_end     = r_long & (r_idx == rbus_wcnt_t'(LONG_WORDS - 1));

    // protocol violations
    assign err_now = (hdr & w_busy)                // long packet cut short
                   | (hdr & hdr_long & l_full)     // no long slot left
                   | (hdr & ~hdr_long & s_full)    // no short slot left
                   | (body & ~w_busy)              // body word outside a packet
                   | (i_frm.sof & ~i_frm.stb);     // sof without strobe

    assign o_avail.short_p = (s_cnt != '0);
    assign o_avail.long_p  = (l_cnt != '0);

    // ----------------------------------------
    // buffers
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (s_wr_en)
        begin
            s_mem[s_wr] <= i_frm.data;
        end
        if (l_wr_en)
        begin
            l_mem[l_wr][l_wr_idx] <= i_frm.data;
        end
    end

    // write control
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            w_busy <= 1'b0;
            w_drop <= 1'b0;
            w_idx  <= '0;
            s_wr   <= '0;
            l_wr   <= '0;
        end
        else
        begin
            if (hdr & hdr_long)
            begin
                w_busy <= 1'b1;            // restarts an unfinished packet too
                w_drop <= l_full;
                w_idx  <= rbus_wcnt_t'(1);
            end
            else if (hdr)
            begin
                w_busy <= 1'b0;            // short header ends a broken long one
            end
            else if (body & w_busy)
            begin
                w_idx <= w_idx + 1'b1;
                if (w_end)
                begin
                    w_busy <= 1'b0;
                end
            end
            if (s_wr_en)
            begin
                s_wr <= (s_wr == sptr_t'(SHORT_SLOTS - 1)) ? '0 : s_wr + 1'b1;
            end
            if (l_wr_done)
            begin
                l_wr <= (l_wr == lptr_t'(LONG_SLOTS - 1)) ? '0 : l_wr + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // readout and credit return
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            s_rd   <= '0;
            l_rd   <= '0;
            r_long <= 1'b0;
            r_idx  <= '0;
            o_word <= '0;
            w_last <= '0;
            o_cred <= '0;
        end
        else
        begin
            o_cred         <= w_last;        // one cycle after the last word
            w_last.short_p <= i_pop.short_p; // short packet is its own last word
            w_last.long_p  <= r_end;
            if (i_pop.short_p)
            begin
                o_word <= '{stb: 1'b1, sof: 1'b1, data: s_mem[s_rd]};
                s_rd   <= (s_rd == sptr_t'(SHORT_SLOTS - 1)) ? '0 : s_rd + 1'b1;
            end
            else if (i_pop.long_p)
            begin
                o_word <= '{stb: 1'b1, sof: 1'b1, data: l_mem[l_rd][0]};
                r_long <= 1'b1;
                r_idx  <= rbus_wcnt_t'(1);
            end
            else if (r_long)
            begin
                o_word <= '{stb: 1'b1, sof: 1'b0, data: l_mem[l_rd][r_idx]};
                r_idx  <= r_idx + 1'b1;
                if (r_end)
                begin
                    r_long <= 1'b0;
                    l_rd   <= (l_rd == lptr_t'(LONG_SLOTS - 1)) ? '0 : l_rd + 1'b1;
                end
            end
            else
            begin
                o_word.stb <= 1'b0;            // data left as is
            end
        end
    end

    // packet and slot counters, error pulse
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            s_cnt  <= '0;
            l_cnt  <= '0;
            s_used <= '0;
            l_used <= '0;
            o_err  <= 1'b0;
        end
        else
        begin
            s_cnt  <= s_cnt + rbus_cred_t'(s_wr_en) - rbus_cred_t'(i_pop.short_p);
            l_cnt  <= l_cnt + rbus_cred_t'(l_wr_done) - rbus_cred_t'(i_pop.long_p);
            s_used <= s_used + rbus_cred_t'(s_wr_en) - rbus_cred_t'(w_last.short_p);
            l_used <= l_used + rbus_cred_t'(l_wr_done) - rbus_cred_t'(w_last.long_p);
            o_err  <= err_now;
        end
    end

endmodule

// ==== logic/rbus_sched.sv ====
// rbus scheduler
// grants one complete packet at a time out of the four class buffers
// in rotating priority, tracks downstream credits per class and
// registers the selected queue word onto the output frame
module rbus_sched (
    input  logic                  clk,
    input  logic                  rst,
    input  rbus_pkg::rbus_class_t i_avail_a,
    input  rbus_pkg::rbus_class_t i_avail_b,
    output rbus_pkg::rbus_class_t o_pop_a,
    output rbus_pkg::rbus_class_t o_pop_b,
    input  rbus_pkg::rbus_frm_t   i_word_a,
    input  rbus_pkg::rbus_frm_t   i_word_b,
    input  rbus_pkg::rbus_class_t i_cred,
    output rbus_pkg::rbus_frm_t   o_frm
);
    import rbus_pkg::*;

    // ----------------------------------------
    // state
    // ----------------------------------------
    sched_state_t state;
    rbus_src_t    ptr;        // last grant, also the packet in flight
    rbus_wcnt_t   wcnt;       // word of the current packet leaving its queue
    rbus_cred_t   cred_s;     // downstream short credits
    rbus_cred_t   cred_l;     // downstream long credits

    rbus_src_t    sel;        // winner of this cycle's arbitration
    logic [3:0]   elig;       // indexed by rbus_src_t
    logic         found;
    logic         cur_long;
    logic         cur_b;
    logic         cur_last;
    logic         can_grant;
    logic         grant;
    logic         grant_s;
    logic         grant_l;

    // candidate at position idx of the order that follows a grant of last
    function automatic rbus_src_t pri_at(input rbus_src_t last, input int unsigned idx);
        rbus_src_t ord [4];
        case (last)
            A_SHORT: ord = '{A_LONG, B_LONG, A_SHORT, B_SHORT};
            A_LONG:  ord = '{B_SHORT, A_SHORT, B_LONG, A_LONG};
            B_SHORT: ord = '{B_LONG, A_LONG, B_SHORT, A_SHORT};
            default: ord = '{A_SHORT, B_SHORT, A_LONG, B_LONG}; // after B_LONG
        endcase
        return ord[idx];
    endfunction

    // ----------------------------------------
    // arbitration
    // ----------------------------------------
    // packet stored and receiver has room
    assign elig[A_SHORT] = i_avail_a.short_p & (cred_s != '0);
    assign elig[A_LONG]  = i_avail_a.long_p  & (cred_l != '0);
    assign elig[B_SHORT] = i_avail_b.short_p & (cred_s != '0);
    assign elig[B_LONG]  = i_avail_b.long_p  & (cred_l != '0);

    always_comb
    begin
        sel   = A_SHORT;
        found = 1'b0;
        for (int unsigned i = 0; i < 4; i++)
        begin
            if (!found && elig[pri_at(ptr, i)])
            begin
                sel   = pri_at(ptr, i);
                found = 1'b1;
            end
        end
    end

    assign cur_long  = (ptr == A_LONG) | (ptr == B_LONG);
    assign cur_b     = (ptr == B_SHORT) | (ptr == B_LONG);
    // last word of the packet is on the queue output now
    assign cur_last  = (state == S_SEND)
                     & (~cur_long | (wcnt == rbus_wcnt_t'(LONG_WORDS - 1)));
    assign can_grant = (state == S_IDLE) | cur_last; // overlap with the tail
    assign grant     = can_grant & found;
    assign grant_s   = grant & ((sel == A_SHORT) | (sel == B_SHORT));
    assign grant_l   = grant & ((sel == A_LONG) | (sel == B_LONG));

    // one-cycle pop towards the granted queue
    assign o_pop_a.short_p = grant & (sel == A_SHORT);
    assign o_pop_a.long_p  = grant & (sel == A_LONG);
    assign o_pop_b.short_p = grant & (sel == B_SHORT);
    assign o_pop_b.long_p  = grant & (sel == B_LONG);

    // ----------------------------------------
    // FSM and word counter
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= S_IDLE;
            ptr   <= A_SHORT;
            wcnt  <= '0;
        end
        else if (grant)
        begin
            state <= S_SEND;
            ptr   <= sel;     // rotates the priority
            wcnt  <= '0;
        end
        else if (cur_last)
        begin
            state <= S_IDLE;  // nothing eligible behind it
        end
        else if (state == S_SEND)
        begin
            wcnt <= wcnt + 1'b1;
        end
    end

    // downstream credits, grant and return in one cycle cancel
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cred_s <= rbus_cred_t'(DOWN_SHORT_CREDITS);
            cred_l <= rbus_cred_t'(DOWN_LONG_CREDITS);
        end
        else
        begin
            cred_s <= cred_s - rbus_cred_t'(grant_s) + rbus_cred_t'(i_cred.short_p);
            cred_l <= cred_l - rbus_cred_t'(grant_l) + rbus_cred_t'(i_cred.long_p);
        end
    end

    // ----------------------------------------
    // output register
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            o_frm <= '0;
        end
        else if (state == S_SEND)
        begin
            o_frm <= cur_b ? i_word_b : i_word_a; // queue word one cycle later
        end
        else
        begin
            o_frm.stb <= 1'b0;                    // data don't care when idle
        end
    end

endmodule

// ==== logic/rbus_mux2to1ch.sv ====
// rbus two-input packet multiplexer
// two class queues feed one rotating-priority scheduler;
// credit flow control on both sides and a sticky error flag
module rbus_mux2to1ch (
    input  logic                  clk,
    input  logic                  rst,
    input  rbus_pkg::rbus_frm_t   i_frm_a,
    input  rbus_pkg::rbus_frm_t   i_frm_b,
    output rbus_pkg::rbus_class_t o_cred_a,
    output rbus_pkg::rbus_class_t o_cred_b,
    output rbus_pkg::rbus_frm_t   o_frm,
    input  rbus_pkg::rbus_class_t i_cred,
    output logic                  o_err
);
    import rbus_pkg::*;

    // queue <-> scheduler
    rbus_class_t avail_a;
    rbus_class_t avail_b;
    rbus_class_t pop_a;
    rbus_class_t pop_b;
    rbus_frm_t   word_a;
    rbus_frm_t   word_b;
    logic        err_a;   // one-cycle violation pulses
    logic        err_b;

    // ----------------------------------------
    // input queues
    // ----------------------------------------
    rbus_class_queue u_queue_a (
        .clk     (clk),
        .rst     (rst),
        .i_frm   (i_frm_a),
        .o_cred  (o_cred_a),
        .o_avail (avail_a),
        .i_pop   (pop_a),
        .o_word  (word_a),
        .o_err   (err_a)
    );

    rbus_class_queue u_queue_b (
        .clk     (clk),
        .rst     (rst),
        .i_frm   (i_frm_b),
        .o_cred  (o_cred_b),
        .o_avail (avail_b),
        .i_pop   (pop_b),
        .o_word  (word_b),
        .o_err   (err_b)
    );

    // ----------------------------------------
    // scheduler and output
    // ----------------------------------------
    rbus_sched u_sched (
        .clk       (clk),
        .rst       (rst),
        .i_avail_a (avail_a),
        .i_avail_b (avail_b),
        .o_pop_a   (pop_a),
        .o_pop_b   (pop_b),
        .i_word_a  (word_a),
        .i_word_b  (word_b),
        .i_cred    (i_cred),
        .o_frm     (o_frm)
    );

    // sticky error, cleared only by reset
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            o_err <= 1'b0;
        end
        else if (err_a | err_b)
        begin
            o_err <= 1'b1;
        end
    end

endmodule

// ==== testbench/rbus_mux2to1ch_asserts.sv ====
// rbus multiplexer checks
// framing, long body payload, downstream credit bound, per-class sequence order,
// rotating priority and the sticky error flag on the top level
module rbus_mux2to1ch_asserts (
    input logic                  clk,
    input logic                  rst,
    input rbus_pkg::rbus_frm_t   o_frm,
    input rbus_pkg::rbus_class_t i_cred,
    input rbus_pkg::rbus_class_t avail_a,
    input rbus_pkg::rbus_class_t avail_b,
    input rbus_pkg::rbus_class_t pop_a,
    input rbus_pkg::rbus_class_t pop_b,
    input logic                  o_err
);
    timeunit 1ns;
    timeprecision 100ps;
    import rbus_pkg::*;

    int          fail_cnt = 0;   // read by the testbench top
    int          body_left;      // long body words still due on o_frm
    logic        body_b;         // current long packet came from input B
    int          out_cnt [2];    // headers out, short / long
    int          ret_cnt [2];    // credits given back downstream
    int          ref_cred [2];   // downstream credits seen by the scheduler
    int          exp_seq [4];    // next sequence number per candidate
    rbus_src_t   last_src;       // source of the previous header
    rbus_src_t   hdr_src;
    logic        hdr;
    logic        hdr_long;
    logic [3:0]  elig;

    // first candidate with a stored packet and a credit, order from the table
    function automatic rbus_src_t pick_next(input rbus_src_t last, input logic [3:0] el);
        logic [7:0] ord;         // four entries, first choice in the low bits
        rbus_src_t  res;
        case (last)
            A_SHORT: ord = {B_SHORT, A_SHORT, B_LONG, A_LONG};
            A_LONG:  ord = {A_LONG, B_LONG, A_SHORT, B_SHORT};
            B_SHORT: ord = {A_SHORT, B_SHORT, A_LONG, B_LONG};
            default: ord = {B_LONG, A_LONG, B_SHORT, A_SHORT};
        endcase
        res = last;
        for (int i = 3; i >= 0; i--)
        begin
            if (el[ord[2*i +: 2]])
            begin
                res = rbus_src_t'(ord[2*i +: 2]);  // lower index wins
            end
        end
        return res;
    endfunction

    assign hdr      = o_frm.stb & o_frm.sof;
    assign hdr_long = o_frm.data[HDR_LONG_BIT];
    assign hdr_src  = rbus_src_t'({o_frm.data[HDR_LONG_BIT - 1], hdr_long}); // test tag
    assign elig[A_SHORT] = avail_a.short_p & (ref_cred[0] > 0);
    assign elig[A_LONG]  = avail_a.long_p  & (ref_cred[1] > 0);
    assign elig[B_SHORT] = avail_b.short_p & (ref_cred[0] > 0);
    assign elig[B_LONG]  = avail_b.long_p  & (ref_cred[1] > 0);

    // ----------------------------------------
    // reference state
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            body_left <= 0;
            body_b    <= 1'b0;
            out_cnt   <= '{0, 0};
            ret_cnt   <= '{0, 0};
            ref_cred  <= '{DOWN_SHORT_CREDITS, DOWN_LONG_CREDITS};
            exp_seq   <= '{0, 0, 0, 0};
            last_src  <= A_SHORT;   // pointer value after reset
        end
        else
        begin
            ref_cred[0] <= ref_cred[0] + int'(i_cred.short_p)
                         - int'(pop_a.short_p | pop_b.short_p);
            ref_cred[1] <= ref_cred[1] + int'(i_cred.long_p)
                         - int'(pop_a.long_p | pop_b.long_p);
            ret_cnt[0]  <= ret_cnt[0] + int'(i_cred.short_p);
            ret_cnt[1]  <= ret_cnt[1] + int'(i_cred.long_p);
            if (hdr)
            begin
                body_left        <= hdr_long ? LONG_WORDS - 1 : 0;
                body_b           <= o_frm.data[HDR_LONG_BIT - 1];
                out_cnt[hdr_long] <= out_cnt[hdr_long] + 1;
                exp_seq[hdr_src] <= exp_seq[hdr_src] + 1;
                last_src         <= hdr_src;
            end
            else if (o_frm.stb && body_left > 0)
            begin
                body_left <= body_left - 1;
            end
        end
    end

    // ----------------------------------------
    // framing
    // ----------------------------------------
    body_gapless: assert property (@(posedge clk) disable iff (rst)
        body_left > 0 |-> o_frm.stb && !o_frm.sof)
        else begin fail_cnt++; $error("long packet body broken at %0t", $time); end

    no_stray_body: assert property (@(posedge clk) disable iff (rst)
        body_left == 0 |-> !(o_frm.stb && !o_frm.sof))
        else begin fail_cnt++; $error("body word outside a packet at %0t", $time); end

    // body payload carries the source and a countdown from LONG_WORDS-1
    body_data: assert property (@(posedge clk) disable iff (rst)
        body_left > 0 |-> o_frm.data == rbus_word_t'({8'(body_b), 8'(body_left)}))
        else begin fail_cnt++; $error("Mismatch at %0t: long packet body word", $time); end

    // header needs a credit left, withheld credits stop the class
    short_credit: assert property (@(posedge clk) disable iff (rst)
        hdr && !hdr_long |-> out_cnt[0] < DOWN_SHORT_CREDITS + ret_cnt[0])
        else begin fail_cnt++; $error("short packet sent without credit at %0t", $time); end

    long_credit: assert property (@(posedge clk) disable iff (rst)
        hdr && hdr_long |-> out_cnt[1] < DOWN_LONG_CREDITS + ret_cnt[1])
        else begin fail_cnt++; $error("long packet sent without credit at %0t", $time); end

    seq_order: assert property (@(posedge clk) disable iff (rst)
        hdr |-> o_frm.data[15:0] == 16'(exp_seq[hdr_src]))
        else begin fail_cnt++; $error("Mismatch at %0t: sequence of source %0d", $time, hdr_src); end

    // grant two cycles before the header
    prio_order: assert property (@(posedge clk) disable iff (rst)
        hdr |-> hdr_src == pick_next(last_src, $past(elig, 2)))
        else begin fail_cnt++; $error("Mismatch at %0t: %0d after %0d", $time, hdr_src, last_src); end

    err_sticky: assert property (@(posedge clk) disable iff (rst)
        o_err |=> o_err)
        else begin fail_cnt++; $error("error flag dropped without reset at %0t", $time); end

endmodule

bind rbus_mux2to1ch rbus_mux2to1ch_asserts u_asserts (
    .clk     (clk),
    .rst     (rst),
    .o_frm   (o_frm),
    .i_cred  (i_cred),
    .avail_a (avail_a),
    .avail_b (avail_b),
    .pop_a   (pop_a),
    .pop_b   (pop_b),
    .o_err   (o_err)
);

// ==== testbench/tb_rbus_mux2to1ch.sv ====
// testbench for the two-input packet multiplexer
// random two-class traffic with credit models on both sides,
// a withheld-credit window, a greedy fill and a forced overflow
module tb_rbus_mux2to1ch;
    timeunit 1ns;
    timeprecision 100ps;
    import rbus_pkg::*;

    localparam int HOLD_CYC = 120;  // withhold window in cycles
    localparam int N_PKT    = 30;   // packets per input and traffic test

    logic        clk;
    logic        rst;
    rbus_frm_t   i_frm_a;
    rbus_frm_t   i_frm_b;
    rbus_class_t o_cred_a;
    rbus_class_t o_cred_b;
    rbus_frm_t   o_frm;
    rbus_class_t i_cred;
    logic        o_err;

    // upstream model, index [input][class], class 0 short, 1 long
    int   left [2];        // packets still to send
    int   body [2];        // body words left of the current long packet
    int   gap [2];
    int   spent [2][2];
    int   ret [2][2];
    int   seq [2][2];
    int   gap_max;
    int   long_pct;
    logic inject;          // short header on input A without credit
    int   words_sent;
    // downstream model
    logic hold;            // keep credits back
    int   dn_delay;
    int   due_s [$];       // return cycles of pending credits
    int   due_l [$];
    int   hdr_out [2];
    int   cyc;
    int   seed;
    int   seed_dn;
    int   n_err;
    int   n_tests;
    int   st [2];
    int   total;

    rbus_mux2to1ch dut (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic int credit(input int i, input int c);
        return (c == 1 ? LONG_SLOTS : SHORT_SLOTS) + ret[i][c] - spent[i][c];
    endfunction

    function automatic rbus_word_t hdr_word(input int src, input int cls, input int n);
        rbus_word_t w;
        w = '0;
        w[HDR_LONG_BIT]     = (cls == 1);
        w[HDR_LONG_BIT - 1] = (src == 1);  // test-only source tag
        w[15:0]             = n[15:0];
        return w;
    endfunction

    function automatic bit drained();
        if (left[0] + left[1] + body[0] + body[1] > 0)
        begin
            return 1'b0;
        end
        for (int i = 0; i < 2; i++)
        begin
            if (ret[i][0] < spent[i][0] || ret[i][1] < spent[i][1])
            begin
                return 1'b0;
            end
        end
        return (hdr_out[0] == spent[0][0] + spent[1][0])
            && (hdr_out[1] == spent[0][1] + spent[1][1])
            && (due_s.size() == 0) && (due_l.size() == 0);
    endfunction

    // ----------------------------------------
    // upstream engine, one word per input and cycle
    // ----------------------------------------
    always @(posedge clk)
    begin
        rbus_frm_t drv [2];
        int        cls;
        int        n_words;
        n_words = 0;
        for (int i = 0; i < 2; i++)
        begin
            drv[i] = '0;
            if (body[i] > 0)
            begin
                drv[i] = '{stb: 1'b1, sof: 1'b0, data: rbus_word_t'({8'(i), 8'(body[i])})};
                body[i]--;
            end
            else if (gap[i] > 0)
            begin
                gap[i]--;
            end
            else if (i == 0 && inject)
            begin
                drv[0] = '{stb: 1'b1, sof: 1'b1, data: hdr_word(0, 0, seq[0][0])};
                inject = 1'b0;
            end
            else if (left[i] > 0)
            begin
                cls = ($unsigned($random(seed)) % 100 < long_pct) ? 1 : 0;
                if (credit(i, cls) == 0)
                begin
                    cls = 1 - cls;                 // other class may have room
                end
                if (credit(i, cls) > 0)
                begin
                    drv[i] = '{stb: 1'b1, sof: 1'b1, data: hdr_word(i, cls, seq[i][cls])};
                    seq[i][cls]++;
                    spent[i][cls]++;
                    left[i]--;
                    body[i] = (cls == 1) ? LONG_WORDS - 1 : 0;
                    gap[i]  = $unsigned($random(seed)) % (gap_max + 1);
                    n_words += (cls == 1) ? LONG_WORDS : 1;
                end
            end
        end
        i_frm_a    <= drv[0];
        i_frm_b    <= drv[1];
        words_sent <= words_sent + n_words;
    end

    // upstream credit pulses
    always @(posedge clk)
    begin
        ret[0][0] <= ret[0][0] + int'(o_cred_a.short_p);
        ret[0][1] <= ret[0][1] + int'(o_cred_a.long_p);
        ret[1][0] <= ret[1][0] + int'(o_cred_b.short_p);
        ret[1][1] <= ret[1][1] + int'(o_cred_b.long_p);
    end

    // downstream model, one credit per header after a random delay
    always @(posedge clk)
    begin
        rbus_class_t pulse;
        pulse = '0;
        if (o_frm.stb && o_frm.sof && o_frm.data[HDR_LONG_BIT])
        begin
            hdr_out[1]++;
            due_l.push_back(cyc + 1 + $unsigned($random(seed_dn)) % dn_delay);
        end
        else if (o_frm.stb && o_frm.sof)
        begin
            hdr_out[0]++;
            due_s.push_back(cyc + 1 + $unsigned($random(seed_dn)) % dn_delay);
        end
        if (!hold && due_s.size() > 0 && due_s[0] <= cyc)
        begin
            void'(due_s.pop_front());
            pulse.short_p = 1'b1;
        end
        if (!hold && due_l.size() > 0 && due_l[0] <= cyc)
        begin
            void'(due_l.pop_front());
            pulse.long_p = 1'b1;
        end
        i_cred <= pulse;
    end

    // timeout, limit grows with the traffic
    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        if (cyc > 4 * words_sent + 200 + HOLD_CYC)
        begin
            $display("timeout after %0d cycles with %0d words sent", cyc, words_sent);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic finish_test(input string name);
        for (int i = 0; i < 2; i++)
        begin
            for (int c = 0; c < 2; c++)
            begin
                assert (ret[i][c] == spent[i][c])
                else begin
                    n_err++;
                    $display("Mismatch at %0t: input %0d class %0d, %0d credits for %0d packets",
                             $time, i, c, ret[i][c], spent[i][c]);
                end
            end
        end
        assert (!o_err)
        else begin
            n_err++;
            $display("error flag set during test %s", name);
        end
        n_tests++;
        $display("test %s done: %0d short, %0d long packets out, %0d failures so far",
                 name, hdr_out[0], hdr_out[1], n_err + dut.u_asserts.fail_cnt);
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial
    begin
        seed     = 32'h6f73_b615;
        seed_dn  = seed ^ 32'h5a5a_5a5a;  // separate stream for the receiver
        rst      = 1'b1;
        i_frm_a  = '0;
        i_frm_b  = '0;
        i_cred   = '0;
        inject   = 1'b0;
        hold     = 1'b0;
        dn_delay = 8;
        gap_max  = 3;
        long_pct = 30;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        left = '{N_PKT, N_PKT};
        while (!drained()) @(negedge clk);
        finish_test("mixed");

        hold = 1'b1;
        st   = hdr_out;
        left = '{N_PKT, N_PKT};
        repeat (HOLD_CYC) @(negedge clk);
        assert (hdr_out[0] - st[0] <= DOWN_SHORT_CREDITS && hdr_out[1] - st[1] <= DOWN_LONG_CREDITS)
        else begin
            n_err++;
            $display("packets left while credits were withheld");
        end
        hold = 1'b0;
        while (!drained()) @(negedge clk);
        finish_test("withhold");

        gap_max  = 0;                 // greedy, keeps all four buffers busy
        long_pct = 50;
        dn_delay = 1;
        left     = '{N_PKT, N_PKT};
        while (!drained()) @(negedge clk);
        finish_test("priority");

        // use up the short credits, fill input A, then overflow it
        hold     = 1'b1;
        long_pct = 0;
        left[0]  = DOWN_SHORT_CREDITS;
        while (left[0] > 0 || ret[0][0] != spent[0][0]) @(negedge clk);
        left[0] = SHORT_SLOTS;
        while (left[0] > 0) @(negedge clk);
        repeat (4) @(negedge clk);
        assert (!o_err)
        else begin
            n_err++;
            $display("error flag set before the overflow");
        end
        inject = 1'b1;
        for (int k = 0; k < 10 && !o_err; k++) @(negedge clk);
        assert (o_err)
        else begin
            n_err++;
            $display("error flag did not rise after the overflow");
        end
        repeat (20) @(negedge clk);   // sticky check runs meanwhile
        @(posedge clk);
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!o_err)
        else begin
            n_err++;
            $display("error flag not cleared by reset");
        end
        n_tests++;
        $display("test error done: flag raised and cleared by reset");

        total = n_err + dut.u_asserts.fail_cnt;
        $display("tests run %0d, failed checks %0d", n_tests, total);
        if (total == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== rbus_mux2to1ch.f ====
logic/rbus_pkg.sv
logic/rbus_class_queue.sv
logic/rbus_sched.sv
logic/rbus_mux2to1ch.sv
testbench/rbus_mux2to1ch_asserts.sv
testbench/tb_rbus_mux2to1ch.sv

// ==== Bender.yml ====
package:
  name: rbus_mux2to1ch

sources:
  - files:
      - logic/rbus_pkg.sv
      - logic/rbus_class_queue.sv
      - logic/rbus_sched.sv
      - logic/rbus_mux2to1ch.sv
  - target: test
    files:
      - testbench/rbus_mux2to1ch_asserts.sv
      - testbench/tb_rbus_mux2to1ch.sv
